// ==== rtl/pad_pkg.sv ====
/*
 * pad-side types: mux source code, pad electrical config, wake edge select
 */
package pad_pkg;

  // ******************************
  // widths
  // ******************************

  // mux code width, one code per pad
  localparam int unsigned MUX_W = 2;
  // drive strength, pull and slew bits
  localparam int unsigned PAD_CFG_W = 6;

  // ******************************
  // types
  // ******************************

  // source of a pad
  typedef enum logic [MUX_W-1:0] {
    MUX_OFF    = 2'd0,
    MUX_GPIO   = 2'd1,
    MUX_PERIO  = 2'd2,
    MUX_FPGAIO = 2'd3
  } mux_sel_t;

  // opaque to the logic, stored and sent to the pad ring
  typedef logic [PAD_CFG_W-1:0] pad_cfg_t;

  // wake polarity per gpio channel
  typedef enum logic {
    EDGE_RISE = 1'b0,
    EDGE_FALL = 1'b1
  } wake_edge_t;

endpackage

// ==== rtl/ctrl_pkg.sv ====
/*
 * register port types, address map and reset sequencer states
 */
package ctrl_pkg;

  // ******************************
  // register port
  // ******************************

  typedef logic [4:0]  reg_addr_t;
  typedef logic [15:0] reg_data_t;

  // ******************************
  // address map
  // ******************************

  // 0 .. N_IO-1 are pad entries
  //   bits 1:0 mux code, bits 7:2 pad config
  // WAKE_BASE + k is wake config of gpio channel k
  //   bit 0 enable, bit 1 edge select
  localparam reg_addr_t WAKE_BASE = 5'd16;
  // any write here clears every wake flag
  localparam reg_addr_t WAKE_CLR = 5'd31;

  // ******************************
  // reset sequencer
  // ******************************

  typedef enum logic [1:0] {
    RST_ASSERT = 2'd0,
    RST_COUNT  = 2'd1,
    RST_DONE   = 2'd2
  } rst_state_t;

endpackage

// ==== rtl/pad_cfg_if.sv ====
/*
 * pad and wake configuration bundle, register block to mux and wake logic
 */
interface pad_cfg_if #(
  parameter int unsigned N_IO   = 8,
  parameter int unsigned N_GPIO = 4
);
  import pad_pkg::*;

  // per pad
  mux_sel_t   [N_IO-1:0]   mux_sel;
  pad_cfg_t   [N_IO-1:0]   pad_cfg;
  // per gpio channel
  logic       [N_GPIO-1:0] wake_en;
  wake_edge_t [N_GPIO-1:0] wake_edge;

  // owner of the state
  modport regs (output mux_sel, output pad_cfg, output wake_en, output wake_edge);
  // pad routing side
  modport mux  (input mux_sel, input pad_cfg);
  // wake detector side
  modport wake (input wake_en, input wake_edge);

endinterface

// ==== rtl/pad_cfg_regs.sv ====
/*
 * pad mux, pad config and wake config registers behind a valid/ready write port
 */
module pad_cfg_regs #(
  parameter int unsigned N_IO   = 8,
  parameter int unsigned N_GPIO = 4
) (
  input  logic                ref_clk_i,
  input  logic                rst_n_i,
  // write port
  input  logic                cfg_valid_i,
  output logic                cfg_ready_o,
  input  ctrl_pkg::reg_addr_t cfg_addr_i,
  input  ctrl_pkg::reg_data_t cfg_wdata_i,
  // one cycle pulse on a WAKE_CLR write
  output logic                wake_clr_o,
  pad_cfg_if.regs             cfg
);
  import pad_pkg::*;
  import ctrl_pkg::*;

  mux_sel_t   [N_IO-1:0]   mux_q;
  pad_cfg_t   [N_IO-1:0]   cfg_q;
  logic       [N_GPIO-1:0] wake_en_q;
  wake_edge_t [N_GPIO-1:0] wake_edge_q;
  logic                    wr_acc;

  // ******************************
  // handshake
  // ******************************

  // ready follows the stretched domain reset
  assign cfg_ready_o = rst_n_i;
  assign wr_acc      = cfg_valid_i & cfg_ready_o;

  // ******************************
  // register file
  // ******************************

  always_ff @(posedge ref_clk_i) begin
    if (!rst_n_i) begin
      // all pads off, config zero
      for (int i = 0; i < int'(N_IO); i++) begin
        mux_q[i] <= MUX_OFF;
        cfg_q[i] <= '0;
      end
      for (int k = 0; k < int'(N_GPIO); k++) begin
        wake_en_q[k]   <= 1'b0;
        wake_edge_q[k] <= EDGE_RISE;
      end
    end else if (wr_acc) begin
      // pad entries
      for (int i = 0; i < int'(N_IO); i++) begin
        if (cfg_addr_i == reg_addr_t'(i)) begin
          mux_q[i] <= mux_sel_t'(cfg_wdata_i[1:0]);
          cfg_q[i] <= cfg_wdata_i[7:2];
        end
      end
      // wake entries, one per gpio channel
      for (int k = 0; k < int'(N_GPIO); k++) begin
        if (cfg_addr_i == reg_addr_t'(WAKE_BASE + k)) begin
          wake_en_q[k]   <= cfg_wdata_i[0];
          wake_edge_q[k] <= wake_edge_t'(cfg_wdata_i[1]);
        end
      end
      // other addresses fall through untouched
    end
  end

  // same cycle as the accept, so flags drop right after the edge
  assign wake_clr_o = wr_acc && (cfg_addr_i == WAKE_CLR);

  // ******************************
  // outputs to users
  // ******************************

  assign cfg.mux_sel   = mux_q;
  assign cfg.pad_cfg   = cfg_q;
  assign cfg.wake_en   = wake_en_q;
  assign cfg.wake_edge = wake_edge_q;

endmodule

// ==== rtl/pad_mux.sv ====
/*
 * combinational pad routing among gpio, perio and fpgaio groups
 */
module pad_mux #(
  parameter int unsigned N_IO     = 8,
  parameter int unsigned N_GPIO   = 4,
  parameter int unsigned N_PERIO  = 4,
  parameter int unsigned N_FPGAIO = 2
) (
  // pad side
  output logic               [N_IO-1:0]     io_out_o,
  output logic               [N_IO-1:0]     io_oe_o,
  input  logic               [N_IO-1:0]     io_in_i,
  output pad_pkg::pad_cfg_t  [N_IO-1:0]     pad_cfg_o,
  // gpio group
  input  logic               [N_GPIO-1:0]   gpio_out_i,
  input  logic               [N_GPIO-1:0]   gpio_oe_i,
  output logic               [N_GPIO-1:0]   gpio_in_o,
  // perio group
  input  logic               [N_PERIO-1:0]  perio_out_i,
  input  logic               [N_PERIO-1:0]  perio_oe_i,
  output logic               [N_PERIO-1:0]  perio_in_o,
  // fpgaio group
  input  logic               [N_FPGAIO-1:0] fpgaio_out_i,
  input  logic               [N_FPGAIO-1:0] fpgaio_oe_i,
  output logic               [N_FPGAIO-1:0] fpgaio_in_o,
  pad_cfg_if.mux                            cfg
);
  import pad_pkg::*;

  // ******************************
  // outbound, pad i takes channel i mod group size
  // ******************************

  always_comb begin
    io_out_o = '0;
    io_oe_o  = '0;
    for (int i = 0; i < int'(N_IO); i++) begin
      case (cfg.mux_sel[i])
        MUX_GPIO: begin
          io_out_o[i] = gpio_out_i[i % N_GPIO];
          io_oe_o[i]  = gpio_oe_i[i % N_GPIO];
        end
        MUX_PERIO: begin
          io_out_o[i] = perio_out_i[i % N_PERIO];
          io_oe_o[i]  = perio_oe_i[i % N_PERIO];
        end
        MUX_FPGAIO: begin
          io_out_o[i] = fpgaio_out_i[i % N_FPGAIO];
          io_oe_o[i]  = fpgaio_oe_i[i % N_FPGAIO];
        end
        // MUX_OFF leaves the pad undriven
        default: ;
      endcase
    end
  end

  // ******************************
  // inbound
  // ******************************

  // walk pads from the top so the lowest matching pad is applied last
  always_comb begin
    gpio_in_o   = '0;
    perio_in_o  = '0;
    fpgaio_in_o = '0;
    for (int i = int'(N_IO) - 1; i >= 0; i--) begin
      if (cfg.mux_sel[i] == MUX_GPIO)   gpio_in_o[i % N_GPIO]     = io_in_i[i];
      if (cfg.mux_sel[i] == MUX_PERIO)  perio_in_o[i % N_PERIO]   = io_in_i[i];
      if (cfg.mux_sel[i] == MUX_FPGAIO) fpgaio_in_o[i % N_FPGAIO] = io_in_i[i];
    end
  end

  // electrical config goes straight to the pads
  assign pad_cfg_o = cfg.pad_cfg;

endmodule

// ==== rtl/rst_gen.sv ====
/*
 * reset stretcher, holds domain reset low RST_HOLD cycles after release
 */
module rst_gen #(
  parameter int unsigned RST_HOLD = 8
) (
  input  logic ref_clk_i,
  input  logic rst_n_i,
  output logic rst_n_o
);
  import ctrl_pkg::*;

  // wide enough to reach RST_HOLD itself
  localparam int unsigned CNT_W = $clog2(RST_HOLD + 1);

  rst_state_t       state_q;
  logic [CNT_W-1:0] cnt_q;
  logic             rst_n_q;

  always_ff @(posedge ref_clk_i) begin
    if (!rst_n_i) begin
      state_q <= RST_ASSERT;
      cnt_q   <= '0;
      rst_n_q <= 1'b0;
    end else begin
      case (state_q)
        // first edge with input high, counts as cycle one
        RST_ASSERT: begin
          state_q <= RST_COUNT;
          cnt_q   <= CNT_W'(1);
        end
        RST_COUNT: begin
          if (cnt_q == CNT_W'(RST_HOLD)) begin
            state_q <= RST_DONE;
            rst_n_q <= 1'b1;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        // stay released until the input drops again
        RST_DONE: rst_n_q <= 1'b1;
        default:  state_q <= RST_ASSERT;
      endcase
    end
  end

  assign rst_n_o = rst_n_q;

endmodule

// ==== rtl/slow_clk_gen.sv ====
/*
 * slow clock divider, toggles every CLK_DIV reference cycles
 */
module slow_clk_gen #(
  parameter int unsigned CLK_DIV = 3
) (
  input  logic ref_clk_i,
  input  logic rst_n_i,
  output logic slow_clk_o
);

  // extra bit so CLK_DIV of 1 still has a counter
  localparam int unsigned CNT_W = $clog2(CLK_DIV + 1);

  logic [CNT_W-1:0] cnt_q;
  logic             clk_q;

  always_ff @(posedge ref_clk_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
      clk_q <= 1'b0;
    end else if (cnt_q == CNT_W'(CLK_DIV - 1)) begin
      // half period done
      cnt_q <= '0;
      clk_q <= ~clk_q;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // straight from the flop, no glitches
  assign slow_clk_o = clk_q;

endmodule

// ==== rtl/gpio_wake.sv ====
/*
 * gpio input synchronizers, edge detect and sticky wake flags
 */
module gpio_wake #(
  parameter int unsigned N_GPIO = 4
) (
  input  logic              ref_clk_i,
  input  logic              rst_n_i,
  input  logic [N_GPIO-1:0] gpio_in_i,
  input  logic              wake_clr_i,
  output logic              wake_o,
  pad_cfg_if.wake           cfg
);
  import pad_pkg::*;

  logic [N_GPIO-1:0] sync1_q;
  logic [N_GPIO-1:0] sync2_q;
  logic [N_GPIO-1:0] prev_q;
  logic [N_GPIO-1:0] flag_q;
  logic [N_GPIO-1:0] hit;

  // ******************************
  // synchronizer and edge register
  // ******************************

  always_ff @(posedge ref_clk_i) begin
    if (!rst_n_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
    end else begin
      sync1_q <= gpio_in_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
    end
  end

  // enabled channel seeing its selected polarity
  always_comb begin
    for (int k = 0; k < int'(N_GPIO); k++) begin
      if (cfg.wake_edge[k] == EDGE_RISE) begin
        hit[k] = cfg.wake_en[k] & sync2_q[k] & ~prev_q[k];
      end else begin
        hit[k] = cfg.wake_en[k] & ~sync2_q[k] & prev_q[k];
      end
    end
  end

  // ******************************
  // sticky flags
  // ******************************

  always_ff @(posedge ref_clk_i) begin
    if (!rst_n_i) begin
      flag_q <= '0;
    end else if (wake_clr_i) begin
      // clear wins over a same-cycle edge
      flag_q <= '0;
    end else begin
      flag_q <= flag_q | hit;
    end
  end

  assign wake_o = |flag_q;

endmodule

// ==== rtl/safe_domain.sv ====
/*
 * always-on domain top: reset stretch, slow clock, pad config, pad mux, gpio wake
 */
module safe_domain #(
  parameter int unsigned N_IO     = 8,
  parameter int unsigned N_GPIO   = 4,
  parameter int unsigned N_PERIO  = 4,
  parameter int unsigned N_FPGAIO = 2,
  parameter int unsigned RST_HOLD = 8,
  parameter int unsigned CLK_DIV  = 3
) (
  input  logic                          ref_clk_i,
  input  logic                          rst_n_i,
  output logic                          rst_n_o,
  output logic                          slow_clk_o,
  // register write port
  input  logic                          cfg_valid_i,
  output logic                          cfg_ready_o,
  input  ctrl_pkg::reg_addr_t           cfg_addr_i,
  input  ctrl_pkg::reg_data_t           cfg_wdata_i,
  // pads
  output pad_pkg::pad_cfg_t [N_IO-1:0]  pad_cfg_o,
  output logic [N_IO-1:0]               io_out_o,
  input  logic [N_IO-1:0]               io_in_i,
  output logic [N_IO-1:0]               io_oe_o,
  // gpio
  input  logic [N_GPIO-1:0]             gpio_out_i,
  output logic [N_GPIO-1:0]             gpio_in_o,
  input  logic [N_GPIO-1:0]             gpio_oe_i,
  // perio
  input  logic [N_PERIO-1:0]            perio_out_i,
  output logic [N_PERIO-1:0]            perio_in_o,
  input  logic [N_PERIO-1:0]            perio_oe_i,
  // fpgaio
  input  logic [N_FPGAIO-1:0]           fpgaio_out_i,
  output logic [N_FPGAIO-1:0]           fpgaio_in_o,
  input  logic [N_FPGAIO-1:0]           fpgaio_oe_i,
  // wake request
  output logic                          wake_o
);

  logic wake_clr;

  pad_cfg_if #(.N_IO(N_IO), .N_GPIO(N_GPIO)) cfg_if ();

  // ******************************
  // reset and clock
  // ******************************

  // rst_n_o is the domain reset for every block below
  rst_gen #(.RST_HOLD(RST_HOLD)) rst_gen_i (
    .ref_clk_i (ref_clk_i),
    .rst_n_i   (rst_n_i),
    .rst_n_o   (rst_n_o)
  );

  slow_clk_gen #(.CLK_DIV(CLK_DIV)) slow_clk_gen_i (
    .ref_clk_i  (ref_clk_i),
    .rst_n_i    (rst_n_o),
    .slow_clk_o (slow_clk_o)
  );

  // ******************************
  // configuration
  // ******************************

  pad_cfg_regs #(.N_IO(N_IO), .N_GPIO(N_GPIO)) pad_cfg_regs_i (
    .ref_clk_i   (ref_clk_i),
    .rst_n_i     (rst_n_o),
    .cfg_valid_i (cfg_valid_i),
    .cfg_ready_o (cfg_ready_o),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .wake_clr_o  (wake_clr),
    .cfg         (cfg_if.regs)
  );

  // ******************************
  // routing and wake
  // ******************************

  pad_mux #(
    .N_IO     (N_IO),
    .N_GPIO   (N_GPIO),
    .N_PERIO  (N_PERIO),
    .N_FPGAIO (N_FPGAIO)
  ) pad_mux_i (
    .io_out_o     (io_out_o),
    .io_oe_o      (io_oe_o),
    .io_in_i      (io_in_i),
    .pad_cfg_o    (pad_cfg_o),
    .gpio_out_i   (gpio_out_i),
    .gpio_oe_i    (gpio_oe_i),
    .gpio_in_o    (gpio_in_o),
    .perio_out_i  (perio_out_i),
    .perio_oe_i   (perio_oe_i),
    .perio_in_o   (perio_in_o),
    .fpgaio_out_i (fpgaio_out_i),
    .fpgaio_oe_i  (fpgaio_oe_i),
    .fpgaio_in_o  (fpgaio_in_o),
    .cfg          (cfg_if.mux)
  );

  // gpio inputs also go to the wake detector
  gpio_wake #(.N_GPIO(N_GPIO)) gpio_wake_i (
    .ref_clk_i  (ref_clk_i),
    .rst_n_i    (rst_n_o),
    .gpio_in_i  (gpio_in_o),
    .wake_clr_i (wake_clr),
    .wake_o     (wake_o),
    .cfg        (cfg_if.wake)
  );

endmodule

// ==== dv/tb_safe_domain.sv ====
/*
 * safe domain testbench with clock, reset, register writes, routing reference,
 * output comparator, slow clock and wake checks, cycle limit
 */
module tb_safe_domain;
  timeunit 1ns;
  timeprecision 1ps;
  import pad_pkg::*;
  import ctrl_pkg::*;

  localparam int N_IO     = 8;
  localparam int N_GPIO   = 4;
  localparam int N_PERIO  = 4;
  localparam int N_FPGAIO = 2;
  localparam int RST_HOLD = 8;
  localparam int CLK_DIV  = 3;
  // random routing rounds of one write per pad plus idle cycles
  localparam int ROUNDS   = 100;
  localparam int IDLE     = 4;
  localparam int UNMAPPED = 40;
  // reset, unmapped writes and wake phases fit in the fixed part
  localparam int EST_CYCLES = ROUNDS * (N_IO + IDLE) + 800;
  localparam int MAX_CYCLES = 2 * EST_CYCLES;

  logic ref_clk, rst_n, rst_n_dom, slow_clk, wake;
  logic cfg_valid, cfg_ready;
  reg_addr_t cfg_addr;
  reg_data_t cfg_wdata;
  pad_cfg_t [N_IO-1:0] pad_cfg;
  logic [N_IO-1:0] io_out, io_in, io_oe;
  logic [N_GPIO-1:0] gpio_out, gpio_in, gpio_oe;
  logic [N_PERIO-1:0] perio_out, perio_in, perio_oe;
  logic [N_FPGAIO-1:0] fpgaio_out, fpgaio_in, fpgaio_oe;

  // register model updated on every accepted write
  mux_sel_t [N_IO-1:0] mux_m;
  pad_cfg_t [N_IO-1:0] cfg_m;

  integer seed;
  string test_name;
  bit route_check_en;
  int route_errs, clk_errs, seq_errs, cycles;
  // slow clock checker state
  logic clk_prev, clk_seen;
  int clk_cnt, clk_toggles;

  safe_domain dut_i (
    .ref_clk_i (ref_clk), .rst_n_i (rst_n), .rst_n_o (rst_n_dom), .slow_clk_o (slow_clk),
    .cfg_valid_i (cfg_valid), .cfg_ready_o (cfg_ready),
    .cfg_addr_i (cfg_addr), .cfg_wdata_i (cfg_wdata),
    .pad_cfg_o (pad_cfg), .io_out_o (io_out), .io_in_i (io_in), .io_oe_o (io_oe),
    .gpio_out_i (gpio_out), .gpio_in_o (gpio_in), .gpio_oe_i (gpio_oe),
    .perio_out_i (perio_out), .perio_in_o (perio_in), .perio_oe_i (perio_oe),
    .fpgaio_out_i (fpgaio_out), .fpgaio_in_o (fpgaio_in), .fpgaio_oe_i (fpgaio_oe),
    .wake_o (wake)
  );

  initial begin
    ref_clk = 1'b0;
    forever #2 ref_clk = ~ref_clk;
  end

  // ******************************
  // helpers
  // ******************************

  function automatic logic [31:0] rand32();
    rand32 = $random(seed);
  endfunction

  task automatic report_mismatch(string test, string what, logic [63:0] exp, logic [63:0] act);
    $display("error %s: %s expected %0h actual %0h", test, what, exp, act);
  endtask

  // pad entries and nothing else change the routing model
  function automatic void model_write(reg_addr_t addr, reg_data_t data);
    int a;
    a = int'(addr);
    if (a < N_IO) begin
      mux_m[a] = mux_sel_t'(data[1:0]);
      cfg_m[a] = data[7:2];
    end
  endfunction

  // lowest pad of a group that lands on channel k or zero when none
  function automatic logic lowest_pad_in(mux_sel_t grp, int size, int k);
    for (int i = 0; i < N_IO; i++) begin
      if (mux_m[i] == grp && i % size == k) return io_in[i];
    end
    return 1'b0;
  endfunction

  function automatic void route_expect(
    output logic [N_IO-1:0]     exp_out,
    output logic [N_IO-1:0]     exp_oe,
    output logic [N_GPIO-1:0]   exp_gpio,
    output logic [N_PERIO-1:0]  exp_perio,
    output logic [N_FPGAIO-1:0] exp_fpgaio
  );
    exp_out = '0;
    exp_oe  = '0;
    for (int i = 0; i < N_IO; i++) begin
      case (mux_m[i])
        MUX_GPIO: begin
          exp_out[i] = gpio_out[i % N_GPIO];
          exp_oe[i]  = gpio_oe[i % N_GPIO];
        end
        MUX_PERIO: begin
          exp_out[i] = perio_out[i % N_PERIO];
          exp_oe[i]  = perio_oe[i % N_PERIO];
        end
        MUX_FPGAIO: begin
          exp_out[i] = fpgaio_out[i % N_FPGAIO];
          exp_oe[i]  = fpgaio_oe[i % N_FPGAIO];
        end
        default: ;
      endcase
    end
    for (int k = 0; k < N_GPIO; k++) exp_gpio[k] = lowest_pad_in(MUX_GPIO, N_GPIO, k);
    for (int k = 0; k < N_PERIO; k++) exp_perio[k] = lowest_pad_in(MUX_PERIO, N_PERIO, k);
    for (int k = 0; k < N_FPGAIO; k++) exp_fpgaio[k] = lowest_pad_in(MUX_FPGAIO, N_FPGAIO, k);
  endfunction

  // called and returns on a falling edge
  task automatic write_reg(reg_addr_t addr, reg_data_t data);
    int waited;
    waited    = 0;
    cfg_valid = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    while (cfg_ready !== 1'b1 && waited < 50) begin
      @(negedge ref_clk);
      waited++;
    end
    if (cfg_ready !== 1'b1) begin
      $display("write to address %0d was never accepted, ready stayed low", addr);
      seq_errs++;
    end else begin
      // accepted on the next rising edge
      @(posedge ref_clk);
      @(negedge ref_clk);
      model_write(addr, data);
    end
    cfg_valid = 1'b0;
  endtask

  task automatic drive_random();
    logic [31:0] r;
    r = rand32();
    io_in = r[N_IO-1:0];
    r = rand32();
    gpio_out = r[N_GPIO-1:0];
    r = rand32();
    gpio_oe = r[N_GPIO-1:0];
    r = rand32();
    perio_out = r[N_PERIO-1:0];
    r = rand32();
    perio_oe = r[N_PERIO-1:0];
    r = rand32();
    fpgaio_out = r[N_FPGAIO-1:0];
    r = rand32();
    fpgaio_oe = r[N_FPGAIO-1:0];
  endtask

  // ******************************
  // comparator
  // ******************************

  // sampled on the rising edge before any register moves
  always @(posedge ref_clk) begin
    logic [N_IO-1:0] e_out, e_oe;
    logic [N_GPIO-1:0] e_gpio;
    logic [N_PERIO-1:0] e_perio;
    logic [N_FPGAIO-1:0] e_fpgaio;
    if (route_check_en) begin
      route_expect(e_out, e_oe, e_gpio, e_perio, e_fpgaio);
      if (io_out !== e_out) begin
        report_mismatch(test_name, "io_out", 64'(e_out), 64'(io_out));
        route_errs++;
      end
      if (io_oe !== e_oe) begin
        report_mismatch(test_name, "io_oe", 64'(e_oe), 64'(io_oe));
        route_errs++;
      end
      if (gpio_in !== e_gpio) begin
        report_mismatch(test_name, "gpio_in", 64'(e_gpio), 64'(gpio_in));
        route_errs++;
      end
      if (perio_in !== e_perio) begin
        report_mismatch(test_name, "perio_in", 64'(e_perio), 64'(perio_in));
        route_errs++;
      end
      if (fpgaio_in !== e_fpgaio) begin
        report_mismatch(test_name, "fpgaio_in", 64'(e_fpgaio), 64'(fpgaio_in));
        route_errs++;
      end
      if (pad_cfg !== cfg_m) begin
        report_mismatch(test_name, "pad_cfg", 64'(cfg_m), 64'(pad_cfg));
        route_errs++;
      end
    end
  end

  // toggle spacing of the slow clock in reference cycles
  always @(negedge ref_clk) begin
    if (rst_n_dom !== 1'b1) begin
      clk_prev = 1'b0;
      clk_seen = 1'b0;
      clk_cnt  = 0;
    end else begin
      clk_cnt++;
      if (slow_clk !== clk_prev) begin
        if (clk_seen && clk_cnt != CLK_DIV) begin
          report_mismatch("slow clock", "toggle interval", 64'(CLK_DIV), 64'(clk_cnt));
          clk_errs++;
        end
        clk_seen = 1'b1;
        clk_cnt  = 0;
        clk_prev = slow_clk;
        clk_toggles++;
      end
    end
  end

  initial begin
    while (cycles < MAX_CYCLES) begin
      @(posedge ref_clk);
      cycles++;
    end
    $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  // ******************************
  // stimulus
  // ******************************

  initial begin
    logic [31:0] r;
    logic [63:0] idle_bits;
    reg_data_t early;
    int low_cycles;
    int lat;
    int a;
    seed = 32'h6ef2_4c9c;
    test_name = "reset";
    route_check_en = 1'b0;
    route_errs = 0;
    clk_errs = 0;
    seq_errs = 0;
    cycles = 0;
    clk_toggles = 0;
    rst_n = 1'b0;
    cfg_valid = 1'b0;
    cfg_addr = '0;
    cfg_wdata = '0;
    io_in = '0;
    gpio_out = '0;
    gpio_oe = '0;
    perio_out = '0;
    perio_oe = '0;
    fpgaio_out = '0;
    fpgaio_oe = '0;
    for (int i = 0; i < N_IO; i++) begin
      mux_m[i] = MUX_OFF;
      cfg_m[i] = '0;
    end

    repeat (4) @(negedge ref_clk);
    if (rst_n_dom !== 1'b0) begin
      report_mismatch(test_name, "rst_n_o in reset", 64'(0), 64'(rst_n_dom));
      seq_errs++;
    end
    // release with a write already waiting on ready
    r = rand32();
    early = r[15:0];
    rst_n = 1'b1;
    cfg_valid = 1'b1;
    cfg_addr = '0;
    cfg_wdata = early;
    low_cycles = 0;
    @(negedge ref_clk);
    while (rst_n_dom !== 1'b1 && low_cycles < 4 * RST_HOLD) begin
      idle_bits = 64'({cfg_ready, wake, slow_clk, io_oe, pad_cfg});
      if (idle_bits !== '0) begin
        report_mismatch(test_name, "idle outputs in stretch", 64'(0), idle_bits);
        seq_errs++;
      end
      low_cycles++;
      @(negedge ref_clk);
    end
    if (low_cycles != RST_HOLD) begin
      report_mismatch(test_name, "stretch cycles", 64'(RST_HOLD), 64'(low_cycles));
      seq_errs++;
    end
    // ready is up and the write not yet taken
    if (cfg_ready !== 1'b1 || pad_cfg[0] !== '0) begin
      report_mismatch(test_name, "ready and pad 0 config", 64'h40, 64'({cfg_ready, pad_cfg[0]}));
      seq_errs++;
    end
    @(posedge ref_clk);
    @(negedge ref_clk);
    model_write('0, early);
    cfg_valid = 1'b0;
    if (pad_cfg[0] !== early[7:2]) begin
      report_mismatch(test_name, "early write pad config", 64'(early[7:2]), 64'(pad_cfg[0]));
      seq_errs++;
    end
    route_check_en = 1'b1;

    // random codes including off and shared channels
    test_name = "routing";
    repeat (ROUNDS) begin
      for (int i = 0; i < N_IO; i++) begin
        r = rand32();
        write_reg(reg_addr_t'(i), r[15:0]);
      end
      repeat (IDLE) begin
        drive_random();
        @(negedge ref_clk);
      end
    end

    // addresses 8..15 and 20..30 hold nothing
    test_name = "unmapped";
    repeat (UNMAPPED) begin
      r = rand32();
      a = r[4] ? 8 + int'(r[2:0]) : 20 + int'(r[3:0]) % 11;
      r = rand32();
      write_reg(reg_addr_t'(a), r[15:0]);
      drive_random();
    end

    // ******************************
    // wake
    // ******************************

    test_name = "wake";
    io_in = '0;
    // pads 1 and 2 on gpio channels 1 and 2 and the rest off
    for (int i = 0; i < N_IO; i++) begin
      write_reg(reg_addr_t'(i), (i == 1 || i == 2) ? 16'(MUX_GPIO) : 16'h0000);
    end
    repeat (4) @(negedge ref_clk);
    // channel 1 enabled on a rising edge
    write_reg(WAKE_BASE + 5'd1, 16'h0001);
    if (wake !== 1'b0) begin
      report_mismatch(test_name, "wake before edge", 64'(0), 64'(wake));
      seq_errs++;
    end
    io_in[1] = 1'b1;
    lat = 0;
    do begin
      @(negedge ref_clk);
      lat++;
    end while (wake !== 1'b1 && lat < 10);
    if (lat != 3) begin
      report_mismatch(test_name, "rise latency", 64'(3), 64'(lat));
      seq_errs++;
    end
    repeat (5) begin
      @(negedge ref_clk);
      if (wake !== 1'b1) begin
        report_mismatch(test_name, "sticky wake", 64'(1), 64'(wake));
        seq_errs++;
      end
    end
    write_reg(WAKE_CLR, 16'h0000);
    if (wake !== 1'b0) begin
      report_mismatch(test_name, "wake after clear", 64'(0), 64'(wake));
      seq_errs++;
    end
    // wrong polarity then a channel that is not enabled
    io_in[1] = 1'b0;
    repeat (6) begin
      @(negedge ref_clk);
      if (wake !== 1'b0) begin
        report_mismatch(test_name, "fall on rise channel", 64'(0), 64'(wake));
        seq_errs++;
      end
    end
    io_in[2] = 1'b1;
    repeat (6) @(negedge ref_clk);
    io_in[2] = 1'b0;
    repeat (6) @(negedge ref_clk);
    if (wake !== 1'b0) begin
      report_mismatch(test_name, "disabled channel", 64'(0), 64'(wake));
      seq_errs++;
    end
    // channel 1 switched to falling edges by bit 1
    write_reg(WAKE_BASE + 5'd1, 16'h0003);
    io_in[1] = 1'b1;
    repeat (6) @(negedge ref_clk);
    if (wake !== 1'b0) begin
      report_mismatch(test_name, "rise on fall channel", 64'(0), 64'(wake));
      seq_errs++;
    end
    io_in[1] = 1'b0;
    lat = 0;
    do begin
      @(negedge ref_clk);
      lat++;
    end while (wake !== 1'b1 && lat < 10);
    if (lat != 3) begin
      report_mismatch(test_name, "fall latency", 64'(3), 64'(lat));
      seq_errs++;
    end
    write_reg(WAKE_CLR, 16'h0000);
    if (wake !== 1'b0) begin
      report_mismatch(test_name, "wake after second clear", 64'(0), 64'(wake));
      seq_errs++;
    end

    repeat (4) @(negedge ref_clk);
    route_check_en = 1'b0;
    if (clk_toggles < 20) begin
      $display("slow clock toggled only %0d times during the run", clk_toggles);
      seq_errs++;
    end
    $display("errors: routing %0d, slow clock %0d, sequence %0d", route_errs, clk_errs, seq_errs);
    if (route_errs + clk_errs + seq_errs == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
rtl/pad_pkg.sv
rtl/ctrl_pkg.sv
rtl/pad_cfg_if.sv
rtl/pad_cfg_regs.sv
rtl/pad_mux.sv
rtl/rst_gen.sv
rtl/slow_clk_gen.sv
rtl/gpio_wake.sv
rtl/safe_domain.sv
dv/tb_safe_domain.sv

// ==== Makefile ====
# Verilator build and run for the safe domain testbench

VERILATOR ?= verilator
VFLAGS    := --binary --timing --timescale 1ns/1ps -j 0
TOP       := tb_safe_domain
FILELIST  := sources.f
OBJDIR    := obj_dir
LOG       := sim.log
PASS_MSG  := TEST PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# pass or fail comes from the log, not from the simulator exit code
run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) && echo "run passed" || \
		(echo "run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
